//--- source/fetch_pkg.sv
package fetch_pkg;

  localparam int ADDR_W = 64;
  localparam int INST_W = 32;
  localparam int WORD_W = 64;       // one memory beat
  localparam int CNT_W  = 8;        // beat index field, up to 256 beats per line

  // addi x0, x0, 0
  localparam logic [INST_W-1:0] NOP_INST = 32'h0000_0013;

  typedef enum logic [1:0] {
    REFILL_IDLE = 2'd0,
    REFILL_REQ  = 2'd1,
    REFILL_FILL = 2'd2,
    REFILL_DONE = 2'd3
  } refill_state_e;

  // handed to decode
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] pc;
    logic [INST_W-1:0] inst;
  } fetch_out_t;

  // line request to memory, addr is line aligned
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
  } mem_req_t;

  // one word written into the line being refilled
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] index;  // line number, i.e. addr without the line offset
    logic [CNT_W-1:0]  beat;
    logic [WORD_W-1:0] data;
  } fill_wr_t;

endpackage

//--- source/pc_gen.sv
`timescale 1ns/10ps

module pc_gen
  import fetch_pkg::*;
#(
  parameter logic [ADDR_W-1:0] RESET_PC = 64'h1000
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              stall_i,
  input  logic              redirect_i,
  input  logic [ADDR_W-1:0] redirect_pc_i,
  input  logic              advance_i,
  output logic [ADDR_W-1:0] pc_o
);

  logic [ADDR_W-1:0] pc_q;
  logic [ADDR_W-1:0] pc_d;

  // redirect wins over stall and over a hit
  always_comb begin
    if (redirect_i) begin
      pc_d = redirect_pc_i;
    end else if (advance_i && !stall_i) begin
      pc_d = pc_q + ADDR_W'(4);  // decode took the instruction
    end else begin
      pc_d = pc_q;               // miss or stall, hold
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

endmodule

//--- source/icache_array.sv
`timescale 1ns/10ps

module icache_array
  import fetch_pkg::*;
#(
  parameter int LINES = 8,
  parameter int BEATS = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [ADDR_W-1:0] pc_i,
  input  fill_wr_t          fill_i,
  input  logic              line_valid_i,
  output logic              hit_o,
  output logic [INST_W-1:0] inst_o
);

  localparam int WOFF_W = $clog2(BEATS);   // word within line
  localparam int IDX_W  = $clog2(LINES);
  localparam int BOFF_W = WOFF_W + 3;      // byte offset within line
  localparam int TAG_W  = ADDR_W - IDX_W - BOFF_W;

  logic [LINES-1:0]  valid_q;
  logic [TAG_W-1:0]  tag_q  [LINES];
  logic [WORD_W-1:0] data_q [LINES][BEATS];

  // lookup fields of the current pc
  logic [TAG_W-1:0]  pc_tag;
  logic [IDX_W-1:0]  pc_idx;
  logic [WOFF_W-1:0] pc_word;
  logic              pc_half;

  // fields of the line being filled
  logic [IDX_W-1:0]  fill_idx;
  logic [TAG_W-1:0]  fill_tag;
  logic [WOFF_W-1:0] fill_word;
  logic [WORD_W-1:0] rd_word;

  assign pc_half = pc_i[2];
  assign pc_word = pc_i[3 +: WOFF_W];
  assign pc_idx  = pc_i[BOFF_W +: IDX_W];
  assign pc_tag  = pc_i[BOFF_W + IDX_W +: TAG_W];

  assign fill_idx  = fill_i.index[IDX_W-1:0];
  assign fill_tag  = fill_i.index[IDX_W +: TAG_W];
  assign fill_word = fill_i.beat[WOFF_W-1:0];

  // a fill drops the old line first, so an aliasing pc evicts it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (fill_i.valid) begin
      valid_q[fill_idx] <= 1'b0;
    end else if (line_valid_i) begin
      valid_q[fill_idx] <= 1'b1;  // index still held by the fsm in DONE
    end
  end

  always_ff @(posedge clk) begin
    if (fill_i.valid) begin
      tag_q[fill_idx]             <= fill_tag;
      data_q[fill_idx][fill_word] <= fill_i.data;
    end
  end

  assign hit_o   = valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);
  assign rd_word = data_q[pc_idx][pc_word];
  assign inst_o  = pc_half ? rd_word[63:32] : rd_word[31:0];  // little endian halves

endmodule

//--- source/icache_fsm.sv
`timescale 1ns/10ps

module icache_fsm
  import fetch_pkg::*;
#(
  parameter int BEATS = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              hit_i,
  input  logic [ADDR_W-1:0] pc_i,
  input  logic              mem_rvalid_i,
  input  logic [WORD_W-1:0] mem_rdata_i,
  input  logic [CNT_W-1:0]  count_i,
  input  logic              last_i,
  output logic              clear_o,
  output mem_req_t          mem_req_o,
  output fill_wr_t          fill_o,
  output logic              line_valid_o,
  output refill_state_e     state_o
);

  localparam int BOFF_W = $clog2(BEATS) + 3;  // bytes per line as a shift

  refill_state_e     state_q;
  refill_state_e     state_d;
  logic [ADDR_W-1:0] line_q;  // line aligned miss address

  always_comb begin
    state_d = state_q;
    case (state_q)
      REFILL_IDLE: if (!hit_i) state_d = REFILL_REQ;
      REFILL_REQ:  state_d = REFILL_FILL;  // single request strobe
      REFILL_FILL: if (mem_rvalid_i && last_i) state_d = REFILL_DONE;
      REFILL_DONE: state_d = REFILL_IDLE;
      default:     state_d = REFILL_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= REFILL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // pc may move on a redirect, the fill keeps this line
  always_ff @(posedge clk) begin
    if (state_q == REFILL_IDLE && !hit_i) begin
      line_q <= {pc_i[ADDR_W-1:BOFF_W], {BOFF_W{1'b0}}};
    end
  end

  always_comb begin
    mem_req_o.valid = (state_q == REFILL_REQ);
    mem_req_o.addr  = line_q;

    fill_o.valid = (state_q == REFILL_FILL) && mem_rvalid_i;
    fill_o.index = line_q >> BOFF_W;
    fill_o.beat  = count_i;  // beats arrive in address order
    fill_o.data  = mem_rdata_i;
  end

  assign clear_o      = (state_q == REFILL_REQ);
  assign line_valid_o = (state_q == REFILL_DONE);
  assign state_o      = state_q;

endmodule

//--- source/beat_counter.sv
`timescale 1ns/10ps

module beat_counter
  import fetch_pkg::*;
#(
  parameter int BEATS = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             clear_i,
  input  logic             beat_i,
  output logic [CNT_W-1:0] count_o,
  output logic             last_o
);

  logic [CNT_W-1:0] count_q;

  assign last_o = beat_i && (count_q == CNT_W'(BEATS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (clear_i) begin
      count_q <= '0;
    end else if (beat_i) begin
      count_q <= last_o ? '0 : count_q + CNT_W'(1);  // wrap after a full line
    end
  end

  assign count_o = count_q;

endmodule

//--- source/if_stage.sv
`timescale 1ns/10ps

module if_stage
  import fetch_pkg::*;
#(
  parameter int                LINES    = 8,
  parameter int                BEATS    = 4,
  parameter logic [ADDR_W-1:0] RESET_PC = 64'h1000
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              stall_i,
  input  logic              redirect_i,
  input  logic [ADDR_W-1:0] redirect_pc_i,
  input  logic              mem_rvalid_i,
  input  logic [WORD_W-1:0] mem_rdata_i,
  output fetch_out_t        fetch_o,
  output mem_req_t          mem_req_o
);

  logic [ADDR_W-1:0] pc;
  logic              hit;
  logic [INST_W-1:0] inst;
  fill_wr_t          fill;
  logic              line_valid;
  logic              cnt_clear;
  logic [CNT_W-1:0]  cnt;
  logic              cnt_last;

  // pc only moves past an instruction the cache delivered
  pc_gen #(
    .RESET_PC (RESET_PC)
  ) pc_gen_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .advance_i     (hit),
    .pc_o          (pc)
  );

  icache_array #(
    .LINES (LINES),
    .BEATS (BEATS)
  ) icache_array_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_i         (pc),
    .fill_i       (fill),
    .line_valid_i (line_valid),
    .hit_o        (hit),
    .inst_o       (inst)
  );

  icache_fsm #(
    .BEATS (BEATS)
  ) icache_fsm_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .hit_i        (hit),
    .pc_i         (pc),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .count_i      (cnt),
    .last_i       (cnt_last),
    .clear_o      (cnt_clear),
    .mem_req_o    (mem_req_o),
    .fill_o       (fill),
    .line_valid_o (line_valid),
    .state_o      ()           // observed by the bound assertions
  );

  beat_counter #(
    .BEATS (BEATS)
  ) beat_counter_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear_i (cnt_clear),
    .beat_i  (mem_rvalid_i),
    .count_o (cnt),
    .last_o  (cnt_last)
  );

  // a redirect squashes whatever sits at the pc this cycle
  always_comb begin
    fetch_o.valid = hit && !redirect_i;
    fetch_o.pc    = pc;
    fetch_o.inst  = fetch_o.valid ? inst : NOP_INST;
  end

endmodule

//--- dv/if_assertions.sv
`timescale 1ns/10ps

module if_assertions
  import fetch_pkg::*;
(
  input logic          clk,
  input logic          rst_n,
  input refill_state_e state_i,
  input logic          hit_i,
  input logic          req_valid_i,
  input logic          beat_i
);

  // one request strobe per miss
  req_pulse: assert property (@(posedge clk) disable iff (!rst_n) req_valid_i |=> !req_valid_i)
    else $error("mem request held for more than one cycle");

  // a request only follows a miss seen while idle
  req_state: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid_i |-> $past(state_i == REFILL_IDLE && !hit_i))
    else $error("mem request sent without a miss in REFILL_IDLE");

  // beats only arrive while the line fills, so none is dropped
  fill_state: assert property (@(posedge clk) disable iff (!rst_n)
    beat_i |-> state_i == REFILL_FILL)
    else $error("memory beat outside REFILL_FILL");

endmodule

bind icache_fsm if_assertions if_assertions_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .state_i     (state_o),
  .hit_i       (hit_i),
  .req_valid_i (mem_req_o.valid),
  .beat_i      (mem_rvalid_i)
);

//--- dv/if_checker.sv
`timescale 1ns/10ps

module if_checker
  import fetch_pkg::*;
#(
  parameter int                BEATS    = 4,
  parameter logic [ADDR_W-1:0] RESET_PC = 64'h1000
) (
  input  logic              clk,
  input  logic              rst_n,
  input  fetch_out_t        fetch_i,
  input  logic [INST_W-1:0] exp_inst_i,
  input  logic              stall_i,
  input  logic              redirect_i,
  input  logic [ADDR_W-1:0] redirect_pc_i,
  input  mem_req_t          mem_req_i,
  output int                err_count_o,
  output int                req_count_o,
  output int                accept_count_o,
  output logic [ADDR_W-1:0] last_pc_o,
  output logic [ADDR_W-1:0] req_addr_o
);

  localparam int BOFF_W = $clog2(BEATS) + 3;

  logic [ADDR_W-1:0] next_pc;  // pc the next accepted instruction must carry

  // decode takes fetch_o on the rising edge, sample there
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_count_o    = 0;
      req_count_o    = 0;
      accept_count_o = 0;
      last_pc_o      = '0;
      req_addr_o     = '0;
      next_pc        = RESET_PC;
    end else begin
      if (mem_req_i.valid) begin
        req_count_o++;
        req_addr_o = mem_req_i.addr;
        if (mem_req_i.addr[BOFF_W-1:0] != '0) begin
          $display("error mem_req_o.addr: %h is not line aligned", mem_req_i.addr);
          err_count_o++;
        end
      end
      if (redirect_i && fetch_i.valid) begin
        $display("error fetch_o.valid: got %h expected 0 in a redirect cycle at pc %h",
                 fetch_i.valid, fetch_i.pc);
        err_count_o++;
      end
      if (!fetch_i.valid && fetch_i.inst !== NOP_INST) begin
        $display("error fetch_o.inst: got %h expected %h", fetch_i.inst, NOP_INST);
        err_count_o++;
      end
      if (fetch_i.valid && !stall_i) begin
        accept_count_o++;
        last_pc_o = fetch_i.pc;
        if (fetch_i.pc !== next_pc) begin
          $display("error fetch_o.pc: got %h expected %h", fetch_i.pc, next_pc);
          err_count_o++;
        end
        if (fetch_i.inst !== exp_inst_i) begin
          $display("error fetch_o.inst: got %h expected %h", fetch_i.inst, exp_inst_i);
          err_count_o++;
        end
        next_pc = fetch_i.pc + 64'd4;
      end
      if (redirect_i) begin
        next_pc = redirect_pc_i;  // target replaces the sequential pc
      end
    end
  end

endmodule

//--- dv/tb_if_stage.sv
`timescale 1ns/10ps

module tb_if_stage
  import fetch_pkg::*;
();

  localparam int                LINES      = 8;
  localparam int                BEATS      = 4;
  localparam logic [ADDR_W-1:0] RESET_PC   = 64'h1000;
  localparam int                TIMEOUT    = 2000;
  localparam int                LINE_BYTES = BEATS * 8;
  localparam int                COLD_LINES = 32 * 4 / LINE_BYTES;
  localparam logic [ADDR_W-1:0] ALIAS_A    = 64'hC000;
  localparam logic [ADDR_W-1:0] ALIAS_B    = ALIAS_A + 64'(LINES * LINE_BYTES);

  logic              clk = 1'b0;
  logic              rst_n;
  logic              stall_i;
  logic              redirect_i;
  logic [ADDR_W-1:0] redirect_pc_i;
  logic              mem_rvalid_i;
  logic [WORD_W-1:0] mem_rdata_i;
  fetch_out_t        fetch_o;
  mem_req_t          mem_req_o;
  logic [INST_W-1:0] exp_inst;

  int                chk_errors;
  int                req_count;
  int                accept_count;
  logic [ADDR_W-1:0] last_pc;
  logic [ADDR_W-1:0] req_addr;
  int                tb_errors    = 0;
  int                tests_failed = 0;
  integer            mem_seed     = 32'h99cb4680;
  integer            stall_seed   = 32'h99cb4680;

  always #5 clk = ~clk;

  // every instruction encodes its own address
  function automatic logic [INST_W-1:0] ref_inst(input logic [ADDR_W-1:0] pc);
    return pc[31:0] ^ 32'h5a5a_0000;
  endfunction

  function automatic logic [WORD_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
    return {ref_inst(a + 64'd4), ref_inst(a)};  // lower half is the lower address
  endfunction

  function automatic int error_total();
    return tb_errors + chk_errors;
  endfunction

  assign exp_inst = ref_inst(fetch_o.pc);

  if_stage #(
    .LINES    (LINES),
    .BEATS    (BEATS),
    .RESET_PC (RESET_PC)
  ) if_stage_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .fetch_o       (fetch_o),
    .mem_req_o     (mem_req_o)
  );

  if_checker #(
    .BEATS    (BEATS),
    .RESET_PC (RESET_PC)
  ) if_checker_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_i        (fetch_o),
    .exp_inst_i     (exp_inst),
    .stall_i        (stall_i),
    .redirect_i     (redirect_i),
    .redirect_pc_i  (redirect_pc_i),
    .mem_req_i      (mem_req_o),
    .err_count_o    (chk_errors),
    .req_count_o    (req_count),
    .accept_count_o (accept_count),
    .last_pc_o      (last_pc),
    .req_addr_o     (req_addr)
  );

  // memory model, beats in address order with random gaps
  initial begin : mem_model
    logic [ADDR_W-1:0] line_addr;
    int                gap;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    forever begin
      @(negedge clk);
      if (mem_req_o.valid) begin
        line_addr = mem_req_o.addr;
        @(negedge clk);  // fsm is in FILL from here on
        for (int b = 0; b < BEATS; b++) begin
          gap          = $random(mem_seed) & 3;
          mem_rvalid_i = 1'b0;
          repeat (gap) @(negedge clk);
          mem_rvalid_i = 1'b1;
          mem_rdata_i  = mem_word(line_addr + 64'(b * 8));
          @(negedge clk);
        end
        mem_rvalid_i = 1'b0;
      end
    end
  end

  task automatic wait_accepts(input int target);
    int cycles;
    cycles = 0;
    while (accept_count < target && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (accept_count < target) begin
      $display("timeout: %0d of %0d instructions accepted", accept_count, target);
      tb_errors++;
    end
  endtask

  task automatic wait_requests(input int target);
    int cycles;
    cycles = 0;
    while (req_count < target && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (req_count < target) begin
      $display("timeout: no memory request seen");
      tb_errors++;
    end
  endtask

  task automatic wait_fetch_valid();
    int cycles;
    cycles = 0;
    while (fetch_o.valid !== 1'b1 && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (fetch_o.valid !== 1'b1) begin
      $display("timeout: fetch_o.valid never went high");
      tb_errors++;
    end
  endtask

  // one cycle strobe, the presented instruction must be squashed
  task automatic redirect_to(input logic [ADDR_W-1:0] target);
    redirect_i    = 1'b1;
    redirect_pc_i = target;
    #1;
    if (fetch_o.valid !== 1'b0) begin
      $display("error fetch_o.valid: got %h expected 0", fetch_o.valid);
      tb_errors++;
    end
    if (fetch_o.inst !== NOP_INST) begin
      $display("error fetch_o.inst: got %h expected %h", fetch_o.inst, NOP_INST);
      tb_errors++;
    end
    @(negedge clk);
    redirect_i = 1'b0;
  endtask

  task automatic run_with_stalls(input int count);
    int target;
    int cycles;
    target = accept_count + count;
    cycles = 0;
    while (accept_count < target && cycles < TIMEOUT) begin
      stall_i = ($random(stall_seed) & 1) != 0;
      @(negedge clk);
      cycles++;
    end
    stall_i = 1'b0;
    if (accept_count < target) begin
      $display("timeout: stalled run stopped at %0d instructions", accept_count);
      tb_errors++;
    end
  endtask

  task automatic check_pc(input logic [ADDR_W-1:0] expected);
    if (last_pc !== expected) begin
      $display("error fetch_o.pc: got %h expected %h", last_pc, expected);
      tb_errors++;
    end
  endtask

  task automatic check_requests(input int got, input int expected);
    if (got != expected) begin
      $display("error mem_req_o count: got %h expected %h", got, expected);
      tb_errors++;
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    if (error_total() == errs_before) begin
      $display("test %0d %s: pass", num, name);
    end else begin
      $display("test %0d %s: fail", num, name);
      tests_failed++;
    end
  endtask

  initial begin : test_seq
    int                base_acc;
    int                base_req;
    int                errs;
    logic [ADDR_W-1:0] target;
    rst_n         = 1'b0;
    stall_i       = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    errs = error_total();
    if (fetch_o.valid !== 1'b0) begin
      $display("error fetch_o.valid: got %h expected 0", fetch_o.valid);
      tb_errors++;
    end
    if (mem_req_o.valid !== 1'b0) begin
      $display("error mem_req_o.valid: got %h expected 0", mem_req_o.valid);
      tb_errors++;
    end
    wait_requests(1);
    if (req_addr !== (RESET_PC & ~(64'(LINE_BYTES) - 64'd1))) begin
      $display("error mem_req_o.addr: got %h expected %h", req_addr,
               RESET_PC & ~(64'(LINE_BYTES) - 64'd1));
      tb_errors++;
    end
    report_test(1, "reset and first request", errs);

    errs = error_total();
    wait_accepts(32);
    check_requests(req_count, COLD_LINES);
    report_test(2, "cold sequential run", errs);

    errs     = error_total();
    base_acc = accept_count;
    redirect_to(RESET_PC);
    @(negedge clk);  // miss on the old pc may still send one request
    base_req = req_count;
    wait_accepts(base_acc + 32);
    check_requests(req_count, base_req);
    report_test(3, "warm rerun", errs);

    errs = error_total();
    run_with_stalls(24);
    report_test(4, "random stalls", errs);

    errs = error_total();
    wait_fetch_valid();
    base_acc = accept_count;
    redirect_to(64'h8000);
    wait_accepts(base_acc + 1);
    check_pc(64'h8000);
    base_acc = accept_count;
    base_req = req_count;
    redirect_to(64'h9000);
    wait_requests(base_req + 1);
    redirect_to(64'hA040);  // lands while the 0x9000 line fills
    wait_accepts(base_acc + 1);
    check_pc(64'hA040);
    report_test(5, "redirects", errs);

    errs = error_total();
    for (int k = 0; k < 4; k++) begin
      target   = (k % 2 == 0) ? ALIAS_A : ALIAS_B;
      base_acc = accept_count;
      base_req = req_count;
      redirect_to(target);
      wait_accepts(base_acc + 1);
      check_pc(target);
      check_requests(req_count, base_req + 1);
    end
    report_test(6, "aliasing eviction", errs);

    $display("%0d of 6 tests failed, %0d errors, %0d requests, %0d instructions",
             tests_failed, error_total(), req_count, accept_count);
    if (error_total() == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
source/fetch_pkg.sv
source/pc_gen.sv
source/icache_array.sv
source/icache_fsm.sv
source/beat_counter.sv
source/if_stage.sv
dv/if_assertions.sv
dv/if_checker.sv
dv/tb_if_stage.sv

//--- run.sh
#!/usr/bin/env bash
# builds the fetch stage testbench with verilator, runs it and looks for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_if_stage -f src.f -o sim_if_stage &&
./obj_dir/sim_if_stage | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
echo "run.sh: simulation ok" ||
{ echo "run.sh: simulation did not pass"; exit 1; }
